// ==== channel/cmp_channel.sv ====
// Completion channel

`timescale 1ns/1ps
`default_nettype none

`include "cmp_config.svh"

module cmp_channel import cmp_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`CMP_ENGINES-1:0] eng_done,
    input  cmp_record_u             eng_data [`CMP_ENGINES],
    output logic [`CMP_ENGINES-1:0] eng_okay,
    input  logic                    wr_fire,
    input  logic                    start,
    input  logic                    ended,
    input  logic [`CMP_SEQ_W-1:0]   last_id,
    output logic                    pending,
    output cmp_record_u             record,
    output logic [`CMP_SEQ_W-1:0]   seq,
    output logic                    irq_set,
    output logic                    done
);

    logic        capture;
    cmp_record_u win_rec;

    // engines only get through while nothing waits for the write port
    assign eng_okay = eng_done & {`CMP_ENGINES{~pending}};

    // lowest accepted engine wins
    always_comb begin
        capture = 1'b0;
        win_rec = eng_data[0];
        for (int e = `CMP_ENGINES - 1; e >= 0; e--) begin
            if (eng_okay[e]) begin
                capture = 1'b1;
                win_rec = eng_data[e];
            end
        end
    end

    // one shot per captured record
    assign irq_set = capture & win_rec.f.irq_req;

    always_ff @(posedge clk) begin
        if (capture) begin
            record <= win_rec;
        end
    end

    // capture needs pending low so it never meets a write accept
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else if (capture) begin
            pending <= 1'b1;
        end else if (wr_fire) begin
            pending <= 1'b0;
        end
    end

    cmp_seq_counter u_seq (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .ended   (ended),
        .wr_fire (wr_fire),
        .last_id (last_id),
        .seq     (seq),
        .done    (done)
    );

endmodule

`default_nettype wire

// ==== channel/cmp_seq_counter.sv ====
// Write sequence counter

`timescale 1ns/1ps
`default_nettype none

`include "cmp_config.svh"

module cmp_seq_counter (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  logic                  ended,
    input  logic                  wr_fire,
    input  logic [`CMP_SEQ_W-1:0] last_id,
    output logic [`CMP_SEQ_W-1:0] seq,
    output logic                  done
);

    logic ended_q;

    // first write of a run carries 1
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seq <= '0;
        end else if (start) begin
            seq <= `CMP_SEQ_W'(1);
        end else if (wr_fire) begin
            seq <= seq + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ended_q <= 1'b0;
        end else if (start) begin
            ended_q <= 1'b0;
        end else if (ended) begin
            ended_q <= 1'b1;
        end
    end

    // all descriptors up to last_id have been written back
    assign done = ended_q & (seq > last_id);

endmodule

`default_nettype wire

// ==== common/cmp_config.svh ====
// Completion manager configuration

`ifndef CMP_CONFIG_SVH
`define CMP_CONFIG_SVH

// channel and engine counts
`define CMP_CHANNELS    4
`define CMP_ENGINES     4

// datapath widths
`define CMP_REC_W       64
`define CMP_ADDR_W      64
`define CMP_WR_DATA_W   128
`define CMP_SEQ_W       30

// interrupt request flag inside a completion record
`define CMP_IRQ_BIT     34

// low bits of every completion write id
`define CMP_ID_TAG      3'b101

// interrupt payload
`define CMP_CTX_W       9
`define CMP_HANDLE_W    64

`endif

// ==== common/cmp_pkg.sv ====
// Completion manager types

`default_nettype none

`include "cmp_config.svh"

package cmp_pkg;

    typedef logic [$clog2(`CMP_CHANNELS)-1:0] ch_idx_t;

    // record as the engines hand it over
    typedef struct packed {
        logic [`CMP_REC_W-`CMP_IRQ_BIT-2:0] status_hi;
        logic                               irq_req;
        logic [`CMP_IRQ_BIT-1:0]            status_lo;
    } cmp_record_t;

    typedef union packed {
        logic [`CMP_REC_W-1:0] raw;
        cmp_record_t           f;
    } cmp_record_u;

    // one completion beat towards the host
    typedef struct packed {
        logic [`CMP_ADDR_W-1:0]             ea;
        logic [`CMP_WR_DATA_W-1:0]          data;
        logic [$bits(ch_idx_t)+2:0]         axi_id;
    } wr_req_t;

    typedef struct packed {
        logic [`CMP_CTX_W-1:0]    ctx;
        logic [`CMP_HANDLE_W-1:0] src;
    } irq_out_t;

endpackage

`default_nettype wire

// ==== filelist.f ====
+incdir+common
common/cmp_pkg.sv
channel/cmp_seq_counter.sv
channel/cmp_channel.sv
verilog/cmp_write_arb.sv
verilog/cmp_irq_fsm.sv
verilog/cmp_top.sv
test/tb_clk_gen.sv
test/tb_cmp_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run the completion manager testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_cmp_top -f filelist.f

./obj_dir/Vtb_cmp_top 2>&1 | tee sim.log

if grep -q "TB FAILED" sim.log; then
    exit 1
fi
exit 0

// ==== test/tb_clk_gen.sv ====
// Testbench clock

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

// ==== test/tb_cmp_top.sv ====
// Completion manager testbench

`timescale 1ns/1ps
`default_nettype none

`include "cmp_config.svh"

module tb_cmp_top import cmp_pkg::*; ();

    localparam int NCH     = `CMP_CHANNELS;
    localparam int NENG    = `CMP_CHANNELS * `CMP_ENGINES;
    localparam int PAD_W   = `CMP_WR_DATA_W - `CMP_REC_W - `CMP_SEQ_W;
    localparam int TIMEOUT = 200;
    localparam int SEED    = 32'h005f_c8aa;

    logic                     clk;
    logic                     rst_n;
    logic [NENG-1:0]          eng_cmp_done;
    cmp_record_u              eng_cmp_data [NENG];
    logic [NENG-1:0]          eng_cmp_okay;
    logic [`CMP_ADDR_W-1:0]   completion_addr [NCH];
    logic [`CMP_HANDLE_W-1:0] cmp_obj_handle [NCH];
    logic [NCH-1:0]           channel_done;
    logic [`CMP_SEQ_W-1:0]    channel_id [NCH];
    logic [NCH-1:0]           manager_start_w;
    logic [NCH-1:0]           completion_done;
    logic                     lcl_wr_valid;
    wr_req_t                  lcl_wr_req;
    logic                     lcl_wr_ready = 1'b0;
    logic                     action_interrupt;
    irq_out_t                 action_irq;
    logic                     action_interrupt_ack;
    logic                     odma_interrupt;
    irq_out_t                 odma_irq;
    logic                     odma_interrupt_ack;

    integer seed       = SEED;
    integer ready_seed = SEED;
    string  test_name  = "reset";
    logic   rand_ready = 1'b0;

    // reference model state, updated at negedge for the coming edge
    logic [NCH-1:0]        m_pend;
    cmp_record_u           m_rec [NCH];
    logic [`CMP_SEQ_W-1:0] m_seq [NCH];
    logic [NCH-1:0]        m_ended;
    logic                  m_valid;
    wr_req_t               m_beat;
    ch_idx_t               m_ch;
    int                    n_writes;
    logic [NCH-1:0]        m_irq;
    int                    m_state;
    ch_idx_t               m_irq_ch;

    tb_clk_gen #(.PERIOD_NS(100)) u_clk (.clk(clk));

    cmp_top uut (.*);

    task automatic check_val(input string what, input logic [255:0] exp_v,
                             input logic [255:0] act_v);
        assert (act_v === exp_v) else begin
            $display("** Error [%s] %s: expected %0h, actual %0h", test_name, what, exp_v, act_v);
            $display("TB FAILED");
            $fatal(1, "%s mismatch", what);
        end
    endtask

    task automatic timeout_abort(input string what);
        $display("timed out waiting for %s during %s", what, test_name);
        $display("TB FAILED");
        $fatal(1, "timeout");
    endtask

    function automatic ch_idx_t lowest_set(input logic [NCH-1:0] v);
        ch_idx_t r;
        r = '0;
        for (int c = NCH - 1; c >= 0; c--) begin
            if (v[c]) begin
                r = ch_idx_t'(c);
            end
        end
        return r;
    endfunction

    // ready is random only while rand_ready is set
    always @(posedge clk) begin
        #1;
        lcl_wr_ready = rand_ready ? (($random(ready_seed) % 2) != 0) : 1'b1;
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        ($past(lcl_wr_valid) && !$past(lcl_wr_ready)) |-> (lcl_wr_valid && $stable(lcl_wr_req)))
    else begin
        $display("** Error [%s] write beat dropped or changed before ready", test_name);
        $display("TB FAILED");
        $fatal(1, "back-pressure stability");
    end

    always @(negedge clk) begin : model
        logic [NENG-1:0] exp_okay;
        logic [NCH-1:0]  exp_done;
        logic [NCH-1:0]  cap;
        logic [NCH-1:0]  irq_new;
        logic [NCH-1:0]  served;
        logic [NCH-1:0]  fired;
        cmp_record_u     cap_rec [NCH];
        if (!rst_n) begin
            m_pend   = '0;
            m_ended  = '0;
            m_valid  = 1'b0;
            m_ch     = '0;
            m_irq    = '0;
            m_state  = 0;
            m_irq_ch = '0;
            n_writes = 0;
            for (int c = 0; c < NCH; c++) begin
                m_seq[c] = '0;
            end
        end else begin
            // lowest engine of a free channel is captured
            cap = '0;
            for (int e = NENG - 1; e >= 0; e--) begin
                exp_okay[e] = eng_cmp_done[e] & ~m_pend[e % NCH];
                if (exp_okay[e]) begin
                    cap[e % NCH]     = 1'b1;
                    cap_rec[e % NCH] = eng_cmp_data[e];
                end
            end
            for (int c = 0; c < NCH; c++) begin
                exp_done[c] = m_ended[c] & (m_seq[c] > channel_id[c]);
                irq_new[c]  = cap[c] & cap_rec[c].f.irq_req;
            end
            check_val("eng_cmp_okay", exp_okay, eng_cmp_okay);
            check_val("completion_done", exp_done, completion_done);
            check_val("lcl_wr_valid", m_valid, lcl_wr_valid);
            if (m_valid) begin
                check_val("lcl_wr_req", m_beat, lcl_wr_req);
            end
            check_val("odma_interrupt", m_state != 0, odma_interrupt);
            check_val("action_interrupt_ack", (m_state == 2) && odma_interrupt_ack,
                      action_interrupt_ack);
            if (m_state == 1) begin
                check_val("odma_irq", {{`CMP_CTX_W{1'b0}}, cmp_obj_handle[m_irq_ch]}, odma_irq);
            end else if (m_state == 2) begin
                check_val("odma_irq", action_irq, odma_irq);
            end
            // beats accepted by the host
            if (lcl_wr_valid && lcl_wr_ready) begin
                n_writes++;
            end
            // write port
            fired = '0;
            if (m_valid && lcl_wr_ready) begin
                fired[m_ch] = 1'b1;
                m_valid     = 1'b0;
            end else if (!m_valid && m_pend != '0) begin
                m_ch    = lowest_set(m_pend);
                m_beat  = {completion_addr[m_ch], m_rec[m_ch].raw, {PAD_W{1'b0}},
                           m_seq[m_ch], m_ch, `CMP_ID_TAG};
                m_valid = 1'b1;
            end
            for (int c = 0; c < NCH; c++) begin
                if (manager_start_w[c]) begin
                    m_seq[c]   = `CMP_SEQ_W'(1);
                    m_ended[c] = 1'b0;
                end else begin
                    if (fired[c]) begin
                        m_seq[c] = m_seq[c] + `CMP_SEQ_W'(1);
                    end
                    if (channel_done[c]) begin
                        m_ended[c] = 1'b1;
                    end
                end
                if (cap[c]) begin
                    m_pend[c] = 1'b1;
                    m_rec[c]  = cap_rec[c];
                end else if (fired[c]) begin
                    m_pend[c] = 1'b0;
                end
            end
            // interrupt FSM serves channels before the action
            served = '0;
            if (m_state == 0) begin
                if (m_irq != '0) begin
                    m_state  = 1;
                    m_irq_ch = lowest_set(m_irq);
                end else if (action_interrupt) begin
                    m_state = 2;
                end
            end else if (odma_interrupt_ack) begin
                if (m_state == 1) begin
                    served[m_irq_ch] = 1'b1;
                end
                m_state = 0;
            end
            m_irq = irq_new | (m_irq & ~served);
        end
    end

    task automatic load_rec(input int idx, input logic irq);
        cmp_record_u r;
        r.raw           = {$random(seed), $random(seed)};
        r.f.irq_req     = irq;
        eng_cmp_data[idx] = r;
    endtask

    // hold done on each engine until it is accepted
    task automatic post(input logic [NENG-1:0] mask);
        logic [NENG-1:0] left;
        int              t;
        left = mask;
        t = 0;
        eng_cmp_done = mask;
        while (left != '0) begin
            @(negedge clk);
            left = left & ~eng_cmp_okay;
            t++;
            if (t > TIMEOUT) begin
                timeout_abort("engine acceptance");
            end
            @(posedge clk);
            #1;
            eng_cmp_done = left;
        end
    endtask

    task automatic wait_idle();
        int t;
        t = 0;
        while (m_pend != '0 || m_valid) begin
            @(posedge clk);
            #1;
            t++;
            if (t > TIMEOUT) begin
                timeout_abort("write port idle");
            end
        end
    endtask

    task automatic serve_irq();
        int t;
        t = 0;
        do begin
            @(negedge clk);
            t++;
            if (t > TIMEOUT) begin
                timeout_abort("odma_interrupt");
            end
        end while (!odma_interrupt);
        @(posedge clk);
        #1;
        odma_interrupt_ack = 1'b1;
        @(posedge clk);
        #1;
        odma_interrupt_ack = 1'b0;
    endtask

    initial begin
        int idx;
        int base;
        rst_n              = 1'b0;
        eng_cmp_done       = '0;
        channel_done       = '0;
        manager_start_w    = '0;
        action_interrupt   = 1'b0;
        action_irq         = '0;
        odma_interrupt_ack = 1'b0;
        for (int i = 0; i < NENG; i++) begin
            eng_cmp_data[i] = '0;
        end
        for (int c = 0; c < NCH; c++) begin
            completion_addr[c] = {$random(seed), $random(seed)};
            cmp_obj_handle[c]  = {$random(seed), $random(seed)};
            channel_id[c]      = `CMP_SEQ_W'(5);
        end
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        manager_start_w = '1;
        @(posedge clk);
        #1;
        manager_start_w = '0;

        test_name = "single_write";
        load_rec(6, 1'b0);
        post(NENG'(1) << 6);
        wait_idle();
        check_val("write count", 1, n_writes);

        test_name = "back_pressure";
        rand_ready = 1'b1;
        for (int k = 0; k < 12; k++) begin
            idx = $random(seed) & 15;
            load_rec(idx, 1'b0);
            post(NENG'(1) << idx);
        end
        wait_idle();

        test_name = "simultaneous";
        base = n_writes;
        load_rec(0, 1'b0);
        load_rec(5, 1'b0);
        load_rec(10, 1'b0);
        load_rec(15, 1'b0);
        post(NENG'(16'h8421));
        wait_idle();
        check_val("write count", base + 4, n_writes);
        rand_ready = 1'b0;

        test_name = "seq_done";
        channel_id[0]   = `CMP_SEQ_W'(2);
        manager_start_w = 4'h1;
        @(posedge clk);
        #1;
        manager_start_w = '0;
        channel_done    = 4'h1;
        @(posedge clk);
        #1;
        channel_done = '0;
        check_val("completion_done before writes", 4'h0, completion_done);
        load_rec(4, 1'b0);
        post(NENG'(1) << 4);
        wait_idle();
        check_val("completion_done after one write", 4'h0, completion_done);
        load_rec(8, 1'b0);
        post(NENG'(1) << 8);
        wait_idle();
        check_val("completion_done after two writes", 4'h1, completion_done);

        test_name = "channel_irq";
        load_rec(7, 1'b1);
        post(NENG'(1) << 7);
        serve_irq();
        wait_idle();

        test_name = "action_irq";
        action_irq.ctx   = `CMP_CTX_W'($random(seed));
        action_irq.src   = {$random(seed), $random(seed)};
        action_interrupt = 1'b1;
        serve_irq();
        action_interrupt = 1'b0;
        repeat (3) @(posedge clk);

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/cmp_irq_fsm.sv ====
// Host interrupt FSM

`timescale 1ns/1ps
`default_nettype none

`include "cmp_config.svh"

module cmp_irq_fsm import cmp_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`CMP_CHANNELS-1:0] irq_set,
    input  logic [`CMP_HANDLE_W-1:0] cmp_obj_handle [`CMP_CHANNELS],
    input  logic                     action_interrupt,
    input  irq_out_t                 action_irq,
    output logic                     action_interrupt_ack,
    output logic                     odma_interrupt,
    output irq_out_t                 odma_irq,
    input  logic                     odma_interrupt_ack
);

    localparam logic [1:0] IDLE    = 2'd0;
    localparam logic [1:0] CH_IRQ  = 2'd1;
    localparam logic [1:0] ACT_IRQ = 2'd2;

    logic [1:0]               state;
    ch_idx_t                  irq_ch;
    ch_idx_t                  low_ch;
    logic [`CMP_CHANNELS-1:0] irq_req;
    logic [`CMP_CHANNELS-1:0] served;
    logic                     ch_ack;

    always_comb begin
        low_ch = '0;
        for (int c = `CMP_CHANNELS - 1; c >= 0; c--) begin
            if (irq_req[c]) begin
                low_ch = ch_idx_t'(c);
            end
        end
    end

    assign ch_ack = (state == CH_IRQ) & odma_interrupt_ack;

    always_comb begin
        for (int c = 0; c < `CMP_CHANNELS; c++) begin
            served[c] = ch_ack & (irq_ch == ch_idx_t'(c));
        end
    end

    // a fresh request survives an ack on the same edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_req <= '0;
        end else begin
            irq_req <= irq_set | (irq_req & ~served);
        end
    end

    // channels go before the action
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= IDLE;
            irq_ch <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (|irq_req) begin
                        state  <= CH_IRQ;
                        irq_ch <= low_ch;
                    end else if (action_interrupt) begin
                        state <= ACT_IRQ;
                    end
                end
                CH_IRQ, ACT_IRQ: begin
                    if (odma_interrupt_ack) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign odma_interrupt       = (state != IDLE);
    assign action_interrupt_ack = (state == ACT_IRQ) & odma_interrupt_ack;

    always_comb begin
        case (state)
            CH_IRQ: begin
                odma_irq.ctx = '0;
                odma_irq.src = cmp_obj_handle[irq_ch];
            end
            ACT_IRQ: odma_irq = action_irq;
            default: odma_irq = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/cmp_top.sv ====
// Completion manager top

`timescale 1ns/1ps
`default_nettype none

`include "cmp_config.svh"

module cmp_top import cmp_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [`CMP_CHANNELS*`CMP_ENGINES-1:0] eng_cmp_done,
    input  cmp_record_u               eng_cmp_data [`CMP_CHANNELS*`CMP_ENGINES],
    output logic [`CMP_CHANNELS*`CMP_ENGINES-1:0] eng_cmp_okay,
    input  logic [`CMP_ADDR_W-1:0]    completion_addr [`CMP_CHANNELS],
    input  logic [`CMP_HANDLE_W-1:0]  cmp_obj_handle [`CMP_CHANNELS],
    input  logic [`CMP_CHANNELS-1:0]  channel_done,
    input  logic [`CMP_SEQ_W-1:0]     channel_id [`CMP_CHANNELS],
    input  logic [`CMP_CHANNELS-1:0]  manager_start_w,
    output logic [`CMP_CHANNELS-1:0]  completion_done,
    output logic                      lcl_wr_valid,
    output wr_req_t                   lcl_wr_req,
    input  logic                      lcl_wr_ready,
    input  logic                      action_interrupt,
    input  irq_out_t                  action_irq,
    output logic                      action_interrupt_ack,
    output logic                      odma_interrupt,
    output irq_out_t                  odma_irq,
    input  logic                      odma_interrupt_ack
);

    logic [`CMP_CHANNELS-1:0] ch_pending;
    logic [`CMP_CHANNELS-1:0] ch_wr_fire;
    logic [`CMP_CHANNELS-1:0] ch_irq_set;
    cmp_record_u              ch_record [`CMP_CHANNELS];
    logic [`CMP_SEQ_W-1:0]    ch_seq [`CMP_CHANNELS];

    for (genvar c = 0; c < `CMP_CHANNELS; c++) begin : g_ch
        logic [`CMP_ENGINES-1:0] eng_done_c;
        logic [`CMP_ENGINES-1:0] eng_okay_c;
        cmp_record_u             eng_data_c [`CMP_ENGINES];

        // engine e of channel c sits at e*channels + c
        for (genvar e = 0; e < `CMP_ENGINES; e++) begin : g_eng
            assign eng_done_c[e] = eng_cmp_done[e*`CMP_CHANNELS+c];
            assign eng_data_c[e] = eng_cmp_data[e*`CMP_CHANNELS+c];
            assign eng_cmp_okay[e*`CMP_CHANNELS+c] = eng_okay_c[e];
        end

        cmp_channel u_channel (
            .clk      (clk),
            .rst_n    (rst_n),
            .eng_done (eng_done_c),
            .eng_data (eng_data_c),
            .eng_okay (eng_okay_c),
            .wr_fire  (ch_wr_fire[c]),
            .start    (manager_start_w[c]),
            .ended    (channel_done[c]),
            .last_id  (channel_id[c]),
            .pending  (ch_pending[c]),
            .record   (ch_record[c]),
            .seq      (ch_seq[c]),
            .irq_set  (ch_irq_set[c]),
            .done     (completion_done[c])
        );
    end

    cmp_write_arb u_write_arb (
        .clk             (clk),
        .rst_n           (rst_n),
        .pending         (ch_pending),
        .record          (ch_record),
        .seq             (ch_seq),
        .completion_addr (completion_addr),
        .wr_fire         (ch_wr_fire),
        .lcl_wr_valid    (lcl_wr_valid),
        .lcl_wr_req      (lcl_wr_req),
        .lcl_wr_ready    (lcl_wr_ready)
    );

    cmp_irq_fsm u_irq_fsm (
        .clk                  (clk),
        .rst_n                (rst_n),
        .irq_set              (ch_irq_set),
        .cmp_obj_handle       (cmp_obj_handle),
        .action_interrupt     (action_interrupt),
        .action_irq           (action_irq),
        .action_interrupt_ack (action_interrupt_ack),
        .odma_interrupt       (odma_interrupt),
        .odma_irq             (odma_irq),
        .odma_interrupt_ack   (odma_interrupt_ack)
    );

endmodule

`default_nettype wire

// ==== verilog/cmp_write_arb.sv ====
// Completion write arbiter

`timescale 1ns/1ps
`default_nettype none

`include "cmp_config.svh"

module cmp_write_arb import cmp_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`CMP_CHANNELS-1:0] pending,
    input  cmp_record_u              record [`CMP_CHANNELS],
    input  logic [`CMP_SEQ_W-1:0]    seq [`CMP_CHANNELS],
    input  logic [`CMP_ADDR_W-1:0]   completion_addr [`CMP_CHANNELS],
    output logic [`CMP_CHANNELS-1:0] wr_fire,
    output logic                     lcl_wr_valid,
    output wr_req_t                  lcl_wr_req,
    input  logic                     lcl_wr_ready
);

    localparam int PAD_W = `CMP_WR_DATA_W - `CMP_REC_W - `CMP_SEQ_W;

    ch_idx_t sel_ch;
    ch_idx_t cur_ch;
    logic    load;

    always_comb begin
        sel_ch = '0;
        for (int c = `CMP_CHANNELS - 1; c >= 0; c--) begin
            if (pending[c]) begin
                sel_ch = ch_idx_t'(c);
            end
        end
    end

    // a new beat is picked only while the port is idle
    assign load = ~lcl_wr_valid & (|pending);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lcl_wr_valid <= 1'b0;
            cur_ch       <= '0;
        end else if (lcl_wr_valid) begin
            if (lcl_wr_ready) begin
                lcl_wr_valid <= 1'b0;
            end
        end else if (load) begin
            lcl_wr_valid <= 1'b1;
            cur_ch       <= sel_ch;
        end
    end

    // beat is frozen while valid is up
    always_ff @(posedge clk) begin
        if (load) begin
            lcl_wr_req.ea     <= completion_addr[sel_ch];
            lcl_wr_req.data   <= {record[sel_ch].raw, {PAD_W{1'b0}}, seq[sel_ch]};
            lcl_wr_req.axi_id <= {sel_ch, `CMP_ID_TAG};
        end
    end

    // accept pulse back to the owning channel
    always_comb begin
        for (int c = 0; c < `CMP_CHANNELS; c++) begin
            wr_fire[c] = lcl_wr_valid & lcl_wr_ready & (cur_ch == ch_idx_t'(c));
        end
    end

endmodule

`default_nettype wire
